/* common/searcher_pkg.sv */
`default_nettype none

package searcher_pkg;

  parameter int TREE_LEVEL = 4;
  parameter int ADDR_W     = 10;
  parameter int DATA_W     = 64;
  // 73 nodes, four per word
  parameter int TREE_WORDS = 19;

  typedef struct packed {
    logic [1:0] level;
    logic [1:0] tree;
    logic [2:0] a;
    logic [2:0] b;
    logic [2:0] c;
  } pos_t;

  typedef struct packed {
    pos_t       pos;
    logic [7:0] mask;
  } entry_t;

  typedef enum logic [1:0] {SCHED_IDLE, SCHED_SEARCH, SCHED_FINISH} sched_state_e;
  typedef enum logic [1:0] {PH_IDLE, PH_WALK, PH_FETCH, PH_DONE} phase_e;
  typedef enum logic [1:0] {WALK_IDLE, WALK_ROOT, WALK_POP, WALK_EXPAND} walk_state_e;
  typedef enum logic [1:0] {FETCH_IDLE, FETCH_POP, FETCH_READ} fetch_state_e;

  //////////////////////////////////////////////////
  // node and feature addressing
  //////////////////////////////////////////////////

  function automatic logic [6:0] node_index(pos_t p);
    logic [6:0] idx;
    case (p.level)
      2'd0:    idx = 7'd0;
      2'd1:    idx = 7'd1 + 7'(p.a);
      default: idx = 7'd9 + {1'b0, p.a, p.b};
    endcase
    return idx;
  endfunction

  // lane inside the word is idx[1:0]
  function automatic logic [ADDR_W-1:0] node_word(pos_t p, logic [ADDR_W-1:0] base);
    logic [6:0] idx;
    idx = node_index(p);
    return base + ADDR_W'(p.tree) * ADDR_W'(TREE_WORDS) + ADDR_W'(idx[6:2]);
  endfunction

  function automatic logic [7:0] feature_row(pos_t p);
    logic [8:0] h;
    logic [7:0] row;
    h = ((9'(p.tree) + 9'd1) * 9'd31) ^ ((9'(p.a) + 9'd1) * 9'd29)
      ^ ((9'(p.b) + 9'd1) * 9'd23) ^ ((9'(p.c) + 9'd1) * 9'd19);
    case (p.level)
      2'd0:    row = 8'(p.a);
      2'd1:    row = 8'd8 + {2'b00, p.a, p.b};
      default: row = 8'd72 + 8'(h[5:0]);
    endcase
    return row;
  endfunction

  // octant goes into the offset slot of the node's own level
  function automatic pos_t set_offset(pos_t p, logic [2:0] oct);
    pos_t r;
    r = p;
    case (p.level)
      2'd0:    r.a = oct;
      2'd1:    r.b = oct;
      default: r.c = oct;
    endcase
    return r;
  endfunction

  function automatic logic [2:0] low_oct(logic [7:0] m);
    logic [2:0] r;
    r = '0;
    for (int i = 7; i >= 0; i--) begin
      if (m[i]) begin
        r = 3'(i);
      end
    end
    return r;
  endfunction

endpackage

`default_nettype wire

/* tree_search/anchor_fifo.sv */
`default_nettype none

module anchor_fifo
  import searcher_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         push,
  input  wire entry_t push_entry,
  input  wire         pop,
  output entry_t      pop_entry,
  output logic        empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  entry_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // depth need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read data stays put until the next pop
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_entry;
    end
    if (pop) begin
      pop_entry <= mem[rd_ptr];
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

`default_nettype wire

/* tree_search/octree_walker.sv */
`default_nettype none

module octree_walker
  import searcher_pkg::*;
#(
  parameter int TREE_BASE = 0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  walk_start,
  input  wire [1:0]            tree_id,
  input  wire [TREE_LEVEL-1:0] lod_mask,
  output logic                 walk_idle,
  output logic                 rd_cen,
  output logic [ADDR_W-1:0]    rd_a,
  input  wire [DATA_W-1:0]     mem_q,
  output logic                 child_push,
  output entry_t               child_entry,
  output logic                 child_pop,
  input  wire entry_t          child_rdata,
  input  wire                  child_empty,
  output logic                 self_push,
  output entry_t               self_entry
);

  walk_state_e state;
  logic        req_vld;
  pos_t        req_pos;
  logic        rsp_vld;
  pos_t        rsp_pos;
  logic [7:0]  done_mask;
  logic [7:0]  pending;
  logic [2:0]  oct;
  pos_t        next_pos;
  logic [6:0]  rsp_idx;
  logic [15:0] node;
  logic [7:0]  child_mask;
  logic [7:0]  self_mask;
  logic        child_ok;
  logic        self_ok;
  logic        busy;

  assign walk_idle = (state == WALK_IDLE);
  assign rd_cen    = ~req_vld;
  assign rd_a      = node_word(req_pos, ADDR_W'(TREE_BASE));
  assign child_pop = (state == WALK_POP) && !child_empty;
  // reads, returned nodes or pushes still on their way
  assign busy      = req_vld | rsp_vld | child_push | self_push;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // lowest octant of the popped entry not yet fetched
  always_comb begin
    pending        = child_rdata.mask & ~done_mask;
    oct            = low_oct(pending);
    next_pos       = set_offset(child_rdata.pos, oct);
    next_pos.level = child_rdata.pos.level + 2'd1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= WALK_IDLE;
      req_vld   <= 1'b0;
      req_pos   <= '0;
      done_mask <= '0;
    end else begin
      req_vld <= 1'b0;
      case (state)
        WALK_IDLE: begin
          if (walk_start) begin
            state <= WALK_ROOT;
          end
        end
        WALK_ROOT: begin
          req_vld <= 1'b1;
          req_pos <= '{level: 2'd0, tree: tree_id, default: '0};
          state   <= WALK_POP;
        end
        WALK_POP: begin
          if (!child_empty) begin
            done_mask <= '0;
            state     <= WALK_EXPAND;
          end else if (!busy) begin
            state <= WALK_IDLE;
          end
        end
        default: begin
          // entry data is held by the FIFO until the next pop
          if (pending != '0) begin
            req_vld        <= 1'b1;
            req_pos        <= next_pos;
            done_mask[oct] <= 1'b1;
          end else begin
            state <= WALK_POP;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  always_comb begin
    rsp_idx = node_index(rsp_pos);
    node    = mem_q[16*rsp_idx[1:0] +: 16];
    for (int i = 0; i < 8; i++) begin
      child_mask[i] = node[2*i];
      self_mask[i]  = node[2*i+1];
    end
    // level 3 is never walked
    child_ok = (rsp_pos.level < 2'd2) && lod_mask[rsp_pos.level + 2'd1];
    self_ok  = lod_mask[rsp_pos.level];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld    <= 1'b0;
      rsp_pos    <= '0;
      child_push <= 1'b0;
      self_push  <= 1'b0;
    end else begin
      rsp_vld    <= req_vld;
      rsp_pos    <= req_pos;
      child_push <= rsp_vld && child_ok && (child_mask != '0);
      self_push  <= rsp_vld && self_ok && (self_mask != '0);
    end
  end

  always_ff @(posedge clk) begin
    child_entry <= '{pos: rsp_pos, mask: child_mask};
    self_entry  <= '{pos: rsp_pos, mask: self_mask};
  end

  // once idle, nothing of the finished walk may still reach the SRAM or FIFOs
  a_no_read_idle: assert property (@(posedge clk) disable iff (!rst_n)
    walk_idle |-> (rd_cen && !child_push && !self_push));

endmodule

`default_nettype wire

/* tree_search/feature_fetcher.sv */
`default_nettype none

module feature_fetcher
  import searcher_pkg::*;
#(
  parameter int FEATURE_BASE   = 80,
  parameter int FEATURE_LENGTH = 4
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                fetch_start,
  input  wire                out_clear,
  output logic               fetch_idle,
  output logic               self_pop,
  input  wire entry_t        self_rdata,
  input  wire                self_empty,
  output logic               rd_cen,
  output logic [ADDR_W-1:0]  rd_a,
  input  wire [DATA_W-1:0]   mem_q,
  output logic               out_cen,
  output logic               out_gwen,
  output logic [ADDR_W-1:0]  out_a,
  output logic [DATA_W-1:0]  out_d
);

  localparam int KW = (FEATURE_LENGTH > 1) ? $clog2(FEATURE_LENGTH) : 1;

  fetch_state_e      state;
  logic [7:0]        done_mask;
  logic [7:0]        pending;
  logic [2:0]        oct;
  logic              last_anchor;
  pos_t              anchor;
  logic [7:0]        row;
  logic [KW-1:0]     word_cnt;
  logic [ADDR_W-1:0] feat_a;
  logic              req_vld;
  logic [ADDR_W-1:0] req_a;
  logic              rsp_vld;
  logic [ADDR_W-1:0] wr_ptr;

  assign fetch_idle = (state == FETCH_IDLE);
  assign self_pop   = (state == FETCH_POP) && !self_empty;
  assign rd_cen     = ~req_vld;
  assign rd_a       = req_a;

  //////////////////////////////////////////////////
  // anchor to feature address
  //////////////////////////////////////////////////

  always_comb begin
    pending     = self_rdata.mask & ~done_mask;
    oct         = low_oct(pending);
    last_anchor = ((pending & ~(8'b1 << oct)) == '0);
    anchor      = set_offset(self_rdata.pos, oct);
    row         = feature_row(anchor);
    feat_a      = ADDR_W'(FEATURE_BASE) + ADDR_W'(row) * ADDR_W'(FEATURE_LENGTH)
                + ADDR_W'(word_cnt);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= FETCH_IDLE;
      done_mask <= '0;
      word_cnt  <= '0;
      req_vld   <= 1'b0;
      req_a     <= '0;
    end else begin
      req_vld <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          if (fetch_start) begin
            state <= FETCH_POP;
          end
        end
        FETCH_POP: begin
          if (!self_empty) begin
            done_mask <= '0;
            word_cnt  <= '0;
            state     <= FETCH_READ;
          end else if (!req_vld && !rsp_vld) begin
            // last word already sits in the output register
            state <= FETCH_IDLE;
          end
        end
        default: begin
          req_vld <= 1'b1;
          req_a   <= feat_a;
          if (word_cnt == KW'(FEATURE_LENGTH - 1)) begin
            word_cnt       <= '0;
            done_mask[oct] <= 1'b1;
            if (last_anchor) begin
              state <= FETCH_POP;
            end
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // output SRAM writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld  <= 1'b0;
      out_cen  <= 1'b1;
      out_gwen <= 1'b1;
      out_a    <= '0;
      wr_ptr   <= '0;
    end else begin
      rsp_vld  <= req_vld;
      out_cen  <= ~rsp_vld;
      out_gwen <= ~rsp_vld;
      // address keeps counting across trees of one search
      if (out_clear) begin
        wr_ptr <= '0;
      end else if (rsp_vld) begin
        out_a  <= wr_ptr;
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_vld) begin
      out_d <= mem_q;
    end
  end

  // after the top address is written, no write until the next search
  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_vld && (wr_ptr == '1)) |=> (!rsp_vld throughout out_clear[->1]));

endmodule

`default_nettype wire

/* tree_search/tree_search.sv */
`default_nettype none

module tree_search
  import searcher_pkg::*;
#(
  parameter int TREE_BASE      = 0,
  parameter int FEATURE_BASE   = 80,
  parameter int FEATURE_LENGTH = 4,
  parameter int CHILD_DEPTH    = 16,
  parameter int SELF_DEPTH     = 80
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  tree_start,
  input  wire [1:0]            tree_id,
  input  wire [TREE_LEVEL-1:0] lod_mask,
  input  wire                  out_clear,
  output logic                 tree_done,
  output logic                 mem_cen,
  output logic [ADDR_W-1:0]    mem_a,
  input  wire [DATA_W-1:0]     mem_q,
  output logic                 out_cen,
  output logic                 out_gwen,
  output logic [ADDR_W-1:0]    out_a,
  output logic [DATA_W-1:0]    out_d
);

  phase_e              phase;
  logic                walk_start;
  logic                walk_idle;
  logic                walk_cen;
  logic [ADDR_W-1:0]   walk_a;
  logic                fetch_start;
  logic                fetch_idle;
  logic                fetch_cen;
  logic [ADDR_W-1:0]   fetch_a;
  logic                child_push;
  entry_t              child_entry;
  logic                child_pop;
  entry_t              child_rdata;
  logic                child_empty;
  logic                self_push;
  entry_t              self_entry;
  logic                self_pop;
  entry_t              self_rdata;
  logic                self_empty;

  assign walk_start  = (phase == PH_IDLE) && tree_start;
  assign fetch_start = (phase == PH_WALK) && walk_idle;
  assign tree_done   = (phase == PH_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= PH_IDLE;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (tree_start) begin
            phase <= PH_WALK;
          end
        end
        PH_WALK: begin
          if (walk_idle) begin
            phase <= PH_FETCH;
          end
        end
        PH_FETCH: begin
          if (fetch_idle) begin
            phase <= PH_DONE;
          end
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  // local SRAM grant follows the phase
  assign mem_cen = (phase == PH_WALK)  ? walk_cen :
                   (phase == PH_FETCH) ? fetch_cen : 1'b1;
  assign mem_a   = (phase == PH_WALK)  ? walk_a :
                   (phase == PH_FETCH) ? fetch_a : '0;

  octree_walker #(
    .TREE_BASE (TREE_BASE)
  ) u_walker (
    .clk         (clk),
    .rst_n       (rst_n),
    .walk_start  (walk_start),
    .tree_id     (tree_id),
    .lod_mask    (lod_mask),
    .walk_idle   (walk_idle),
    .rd_cen      (walk_cen),
    .rd_a        (walk_a),
    .mem_q       (mem_q),
    .child_push  (child_push),
    .child_entry (child_entry),
    .child_pop   (child_pop),
    .child_rdata (child_rdata),
    .child_empty (child_empty),
    .self_push   (self_push),
    .self_entry  (self_entry)
  );

  anchor_fifo #(
    .DEPTH (CHILD_DEPTH)
  ) u_child_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (child_push),
    .push_entry (child_entry),
    .pop        (child_pop),
    .pop_entry  (child_rdata),
    .empty      (child_empty)
  );

  anchor_fifo #(
    .DEPTH (SELF_DEPTH)
  ) u_self_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (self_push),
    .push_entry (self_entry),
    .pop        (self_pop),
    .pop_entry  (self_rdata),
    .empty      (self_empty)
  );

  feature_fetcher #(
    .FEATURE_BASE   (FEATURE_BASE),
    .FEATURE_LENGTH (FEATURE_LENGTH)
  ) u_fetcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_start (fetch_start),
    .out_clear   (out_clear),
    .fetch_idle  (fetch_idle),
    .self_pop    (self_pop),
    .self_rdata  (self_rdata),
    .self_empty  (self_empty),
    .rd_cen      (fetch_cen),
    .rd_a        (fetch_a),
    .mem_q       (mem_q),
    .out_cen     (out_cen),
    .out_gwen    (out_gwen),
    .out_a       (out_a),
    .out_d       (out_d)
  );

endmodule

`default_nettype wire

/* source/search_scheduler.sv */
`default_nettype none

module search_scheduler
  import searcher_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        search_start,
  input  wire [2:0]  tree_num,
  input  wire        tree_done,
  output logic       tree_start,
  output logic [1:0] tree_id,
  output logic       out_clear,
  output logic       search_done
);

  sched_state_e state;

  assign search_done = (state == SCHED_FINISH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= SCHED_IDLE;
      tree_start <= 1'b0;
      tree_id    <= '0;
      out_clear  <= 1'b0;
    end else begin
      tree_start <= 1'b0;
      out_clear  <= 1'b0;
      case (state)
        SCHED_IDLE: begin
          // start is only taken here
          if (search_start) begin
            tree_id    <= '0;
            tree_start <= 1'b1;
            out_clear  <= 1'b1;
            state      <= SCHED_SEARCH;
          end
        end
        SCHED_SEARCH: begin
          if (tree_done) begin
            if ({1'b0, tree_id} == tree_num - 3'd1) begin
              state <= SCHED_FINISH;
            end else begin
              tree_id    <= tree_id + 2'd1;
              tree_start <= 1'b1;
            end
          end
        end
        default: begin
          state <= SCHED_IDLE;
        end
      endcase
    end
  end

  // a tree only finishes after it was started
  a_done_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SCHED_IDLE) |-> !tree_done);

endmodule

`default_nettype wire

/* source/searcher_top.sv */
`default_nettype none

module searcher_top
  import searcher_pkg::*;
#(
  parameter int TREE_BASE      = 0,
  parameter int FEATURE_BASE   = 80,
  parameter int FEATURE_LENGTH = 4,
  parameter int CHILD_DEPTH    = 16,
  parameter int SELF_DEPTH     = 80
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  search_start,
  output logic                 search_done,
  input  wire [2:0]            tree_num,
  input  wire [TREE_LEVEL-1:0] lod_mask,
  output logic                 mem_cen,
  output logic [ADDR_W-1:0]    mem_a,
  input  wire [DATA_W-1:0]     mem_q,
  output logic                 out_cen,
  output logic                 out_gwen,
  output logic [ADDR_W-1:0]    out_a,
  output logic [DATA_W-1:0]    out_d
);

  logic       tree_start;
  logic [1:0] tree_id;
  logic       tree_done;
  logic       out_clear;

  search_scheduler u_scheduler (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_start (search_start),
    .tree_num     (tree_num),
    .tree_done    (tree_done),
    .tree_start   (tree_start),
    .tree_id      (tree_id),
    .out_clear    (out_clear),
    .search_done  (search_done)
  );

  tree_search #(
    .TREE_BASE      (TREE_BASE),
    .FEATURE_BASE   (FEATURE_BASE),
    .FEATURE_LENGTH (FEATURE_LENGTH),
    .CHILD_DEPTH    (CHILD_DEPTH),
    .SELF_DEPTH     (SELF_DEPTH)
  ) u_tree_search (
    .clk        (clk),
    .rst_n      (rst_n),
    .tree_start (tree_start),
    .tree_id    (tree_id),
    .lod_mask   (lod_mask),
    .out_clear  (out_clear),
    .tree_done  (tree_done),
    .mem_cen    (mem_cen),
    .mem_a      (mem_a),
    .mem_q      (mem_q),
    .out_cen    (out_cen),
    .out_gwen   (out_gwen),
    .out_a      (out_a),
    .out_d      (out_d)
  );

endmodule

`default_nettype wire

/* testbench/sram_model.sv */
`default_nettype none

module sram_model #(
  parameter int ADDR_W = 10,
  parameter int DATA_W = 64
) (
  input  wire              clk,
  input  wire              cen,
  input  wire              gwen,
  input  wire [ADDR_W-1:0] a,
  input  wire [DATA_W-1:0] d,
  output logic [DATA_W-1:0] q
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // enable and write are active low
  always @(posedge clk) begin
    if (!cen) begin
      if (!gwen) begin
        mem[a] <= d;
      end else begin
        // read data shows up one cycle after the address
        q <= mem[a];
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_searcher.sv */
`default_nettype none

module tb_searcher
  import searcher_pkg::*;
();

  localparam int TREE_BASE      = 0;
  localparam int FEATURE_BASE   = 80;
  localparam int FEATURE_LENGTH = 4;
  localparam int TIMEOUT        = 20000;

  logic                  clk;
  logic                  rst_n;
  logic                  search_start;
  logic                  search_done;
  logic [2:0]            tree_num;
  logic [TREE_LEVEL-1:0] lod_mask;
  logic                  mem_cen;
  logic [ADDR_W-1:0]     mem_a;
  logic [DATA_W-1:0]     mem_q;
  logic                  out_cen;
  logic                  out_gwen;
  logic [ADDR_W-1:0]     out_a;
  logic [DATA_W-1:0]     out_d;
  logic [DATA_W-1:0]     out_q;

  int                    errors;
  int                    checks;
  int                    timeouts;
  logic [31:0]           rng;
  logic [15:0]           nodes [4][73];
  int                    child_q[$];
  int                    self_q[$];
  logic [DATA_W-1:0]     exp_q[$];
  logic [DATA_W-1:0]     rec_d[$];
  logic [ADDR_W-1:0]     rec_a[$];

  searcher_top #(
    .TREE_BASE      (TREE_BASE),
    .FEATURE_BASE   (FEATURE_BASE),
    .FEATURE_LENGTH (FEATURE_LENGTH)
  ) u_searcher_top (.*);

  sram_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_local_sram (
    .clk  (clk),
    .cen  (mem_cen),
    .gwen (1'b1),
    .a    (mem_a),
    .d    ({DATA_W{1'b0}}),
    .q    (mem_q)
  );

  sram_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_out_sram (
    .clk  (clk),
    .cen  (out_cen),
    .gwen (out_gwen),
    .a    (out_a),
    .d    (out_d),
    .q    (out_q)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // writes as seen on the output port
  always @(negedge clk) begin
    if (rst_n && !out_cen && !out_gwen) begin
      rec_a.push_back(out_a);
      rec_d.push_back(out_d);
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error @ %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // memory contents and reference model
  //////////////////////////////////////////////////

  function automatic logic [15:0] next_rand();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[31:16];
  endfunction

  // tag plus a scramble of the full address
  function automatic logic [DATA_W-1:0] feat_word(input int addr);
    return {16'hfea7, 16'(addr), 32'(addr) * 32'h9e37_79b9 ^ 32'h5a5a_0000};
  endfunction

  function automatic int node_slot(input int lvl, input int a, input int b);
    if (lvl == 0) begin
      return 0;
    end else if (lvl == 1) begin
      return 1 + a;
    end
    return 9 + 8 * a + b;
  endfunction

  function automatic int anchor_row(input int t, input int lvl, input int a, input int b,
                                    input int o);
    if (lvl == 0) begin
      return o;
    end else if (lvl == 1) begin
      return 8 + 8 * a + o;
    end
    return 72 + ((((t + 1) * 31) ^ ((a + 1) * 29) ^ ((b + 1) * 23) ^ ((o + 1) * 19)) & 63);
  endfunction

  task automatic clear_trees();
    for (int t = 0; t < 4; t++) begin
      for (int i = 0; i < 73; i++) begin
        nodes[t][i] = '0;
      end
    end
  endtask

  // sparse masks, one forced root anchor and a forced path down to a level-2 anchor
  task automatic random_tree(input int t);
    for (int i = 0; i < 73; i++) begin
      nodes[t][i] = next_rand() & next_rand();
    end
    nodes[t][0] = nodes[t][0] | 16'h0003;
    nodes[t][1] = nodes[t][1] | 16'h0001;
    nodes[t][9] = nodes[t][9] | 16'h0002;
  endtask

  task automatic load_nodes();
    logic [DATA_W-1:0] word;
    int                w;
    for (int i = 0; i < 4 * TREE_WORDS; i++) begin
      u_local_sram.mem[TREE_BASE + i] = '0;
    end
    for (int t = 0; t < 4; t++) begin
      for (int i = 0; i < 73; i++) begin
        w = TREE_BASE + t * TREE_WORDS + i / 4;
        word = u_local_sram.mem[w];
        word[16 * (i % 4) +: 16] = nodes[t][i];
        u_local_sram.mem[w] = word;
      end
    end
  endtask

  task automatic visit_node(input int t, input int lvl, input int a, input int b,
                            input logic [TREE_LEVEL-1:0] lod);
    logic [15:0] n;
    logic [7:0]  cm;
    logic [7:0]  sm;
    int          e;
    n = nodes[t][node_slot(lvl, a, b)];
    for (int i = 0; i < 8; i++) begin
      cm[i] = n[2 * i];
      sm[i] = n[2 * i + 1];
    end
    e = (lvl << 14) | (a << 11) | (b << 8);
    if (cm != 0 && lvl < 2 && lod[lvl + 1]) begin
      child_q.push_back(e | int'(cm));
    end
    if (sm != 0 && lod[lvl]) begin
      self_q.push_back(e | int'(sm));
    end
  endtask

  task automatic build_expected(input int ntree, input logic [TREE_LEVEL-1:0] lod);
    int e;
    int lvl;
    int a;
    int b;
    int row;
    exp_q.delete();
    for (int t = 0; t < ntree; t++) begin
      child_q.delete();
      self_q.delete();
      visit_node(t, 0, 0, 0, lod);
      // breadth first, children in ascending octant order
      while (child_q.size() > 0) begin
        e = child_q.pop_front();
        lvl = (e >> 14) & 3;
        a = (e >> 11) & 7;
        for (int o = 0; o < 8; o++) begin
          if (e[o] && lvl == 0) begin
            visit_node(t, 1, o, 0, lod);
          end else if (e[o]) begin
            visit_node(t, 2, a, o, lod);
          end
        end
      end
      while (self_q.size() > 0) begin
        e = self_q.pop_front();
        lvl = (e >> 14) & 3;
        a = (e >> 11) & 7;
        b = (e >> 8) & 7;
        for (int o = 0; o < 8; o++) begin
          if (e[o]) begin
            row = anchor_row(t, lvl, a, b, o);
            for (int k = 0; k < FEATURE_LENGTH; k++) begin
              exp_q.push_back(feat_word(FEATURE_BASE + row * FEATURE_LENGTH + k));
            end
          end
        end
      end
    end
  endtask

  task automatic run_search(input int ntree, input logic [TREE_LEVEL-1:0] lod,
                            input string name);
    int cyc;
    if (timeouts > 0) begin
      return;
    end
    build_expected(ntree, lod);
    rec_a.delete();
    rec_d.delete();
    for (int i = 0; i < 2 ** ADDR_W; i++) begin
      u_out_sram.mem[i] = '0;
    end
    tree_num = 3'(ntree);
    lod_mask = lod;
    search_start = 1'b1;
    @(posedge clk);
    #1;
    search_start = 1'b0;
    cyc = 0;
    while (!search_done && cyc < TIMEOUT) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (!search_done) begin
      timeouts++;
      $display("%s: search_done did not arrive within %0d cycles", name, TIMEOUT);
      return;
    end
    // scheduler takes a new start only once back in idle
    @(posedge clk);
    #1;
    check_count(rec_d.size(), exp_q.size(), {name, " write count"});
    for (int i = 0; i < exp_q.size() && i < rec_d.size(); i++) begin
      check_addr(rec_a[i], ADDR_W'(i), $sformatf("%s address of write %0d", name, i));
      check_word(rec_d[i], exp_q[i], $sformatf("%s data of write %0d", name, i));
      check_word(u_out_sram.mem[i], exp_q[i], $sformatf("%s output word %0d", name, i));
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_idle();
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      #1;
      check_bit(mem_cen, 1'b1, "mem_cen at rest");
      check_bit(out_cen, 1'b1, "out_cen at rest");
      check_bit(out_gwen, 1'b1, "out_gwen at rest");
      check_bit(search_done, 1'b0, "search_done at rest");
    end
  endtask

  // self bits at octants 1, 3 and 6, no children
  task automatic test_root_only();
    clear_trees();
    nodes[0][0] = 16'h2088;
    load_nodes();
    run_search(1, 4'b1111, "root only");
  endtask

  task automatic test_random_tree();
    clear_trees();
    random_tree(0);
    load_nodes();
    run_search(1, 4'b1111, "random tree");
  endtask

  task automatic test_lod_cut();
    run_search(1, 4'b1101, "level 1 masked");
  endtask

  task automatic test_multi_tree();
    clear_trees();
    for (int t = 0; t < 3; t++) begin
      random_tree(t);
    end
    load_nodes();
    run_search(3, 4'b1111, "three trees");
    run_search(3, 4'b1111, "three trees again");
  endtask

  task automatic test_empty_tree();
    clear_trees();
    load_nodes();
    run_search(1, 4'b1111, "empty tree");
  endtask

  initial begin
    errors = 0;
    checks = 0;
    timeouts = 0;
    rng = 32'habd6;
    rst_n = 1'b0;
    search_start = 1'b0;
    tree_num = 3'd1;
    lod_mask = '1;
    for (int i = 0; i < 2 ** ADDR_W; i++) begin
      u_local_sram.mem[i] = feat_word(i);
    end
    clear_trees();
    load_nodes();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_idle();
    test_root_only();
    test_random_tree();
    test_lod_cut();
    test_multi_tree();
    test_empty_tree();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
common/searcher_pkg.sv
tree_search/anchor_fifo.sv
tree_search/octree_walker.sv
tree_search/feature_fetcher.sv
tree_search/tree_search.sv
source/search_scheduler.sv
source/searcher_top.sv
testbench/sram_model.sv
testbench/tb_searcher.sv

/* Bender.yml */
package:
  name: octree_searcher

sources:
  - common/searcher_pkg.sv
  - tree_search/anchor_fifo.sv
  - tree_search/octree_walker.sv
  - tree_search/feature_fetcher.sv
  - tree_search/tree_search.sv
  - source/search_scheduler.sv
  - source/searcher_top.sv
  - target: test
    files:
      - testbench/sram_model.sv
      - testbench/tb_searcher.sv
